/* src/osf_cfg_pkg.sv */
package osf_cfg_pkg;

	//////////////////////////////
	// channel layout
	//////////////////////////////

	localparam int N_CHAN = 4;		// filters sharing one result bus
	localparam int CHAN_W = 2;		// tag width on the result bus

	//////////////////////////////
	// datapath widths
	//////////////////////////////

	localparam int W_IN = 18;		// signed adc sample
	localparam int W_OUT = 18;		// signed averaged result

	// log2 of the oversample ratio
	// os 0..7 gives ratios 1..128
	localparam int W_OS = 3;

	// settling delay in valid samples
	// also sizes the shared window/delay counter
	localparam int W_DELAY = 16;

	// accumulator headroom for 2^7 full scale samples
	localparam int SUM_W = W_IN + 7;

endpackage

/* src/osf_types_pkg.sv */
package osf_types_pkg;

	//////////////////////////////
	// adc side
	//////////////////////////////

	// one sample plus its strobe
	typedef struct packed {
		logic signed [osf_cfg_pkg::W_IN-1:0] data;
		logic valid;		// one cycle per sample
	} adc_sample_t;

	typedef adc_sample_t [osf_cfg_pkg::N_CHAN-1:0] adc_bus_t;	// all channels

	//////////////////////////////
	// channel settings
	//////////////////////////////

	// latched settings a filter runs on
	typedef struct packed {
		logic [osf_cfg_pkg::W_OS-1:0] os;			// log2 ratio
		logic [osf_cfg_pkg::W_DELAY-1:0] delay;		// samples skipped between windows
		logic active;								// low holds the filter in idle
	} chan_param_t;

	// live front panel word with the same fields
	typedef struct packed {
		logic [osf_cfg_pkg::W_OS-1:0] os;
		logic [osf_cfg_pkg::W_DELAY-1:0] delay;
		logic active;
	} param_word_t;

	typedef param_word_t [osf_cfg_pkg::N_CHAN-1:0] panel_t;		// panel input
	typedef chan_param_t [osf_cfg_pkg::N_CHAN-1:0] param_vec_t;	// bank output

	//////////////////////////////
	// result side
	//////////////////////////////

	// tagged result on the shared bus
	typedef struct packed {
		logic [osf_cfg_pkg::CHAN_W-1:0] chan;
		logic signed [osf_cfg_pkg::W_OUT-1:0] data;
	} osf_result_t;

	// one filter output before arbitration
	typedef struct packed {
		logic signed [osf_cfg_pkg::W_OUT-1:0] data;
		logic valid;
	} chan_out_t;

	typedef chan_out_t [osf_cfg_pkg::N_CHAN-1:0] result_vec_t;	// filters to arbiter

endpackage

/* src/oversample_filter.sv */
`timescale 1ns/1ps

module oversample_filter (
	input  logic clk_in,
	input  logic reset_in,
	input  osf_types_pkg::adc_sample_t sample,		// one channel of the adc bus
	input  osf_types_pkg::chan_param_t param,		// latched bank settings
	output logic signed [osf_cfg_pkg::W_OUT-1:0] out_data,
	output logic out_valid
);

	//////////////////////////////
	// declarations
	//////////////////////////////

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DELAY,
		ST_SAMPLE,
		ST_SEND
	} state_t;

	state_t state;
	state_t state_nxt;

	logic [osf_cfg_pkg::W_DELAY-1:0] cnt;			// valid samples seen in this state
	logic [osf_cfg_pkg::W_DELAY-1:0] win_last;		// 2^os - 1
	logic [osf_cfg_pkg::W_DELAY-1:0] dly_last;		// delay - 1
	logic [osf_cfg_pkg::W_OS-1:0] os_cur;			// ratio of the running window
	logic [osf_cfg_pkg::W_DELAY-1:0] delay_cur;	// delay after the running window
	logic signed [osf_cfg_pkg::SUM_W-1:0] sum;
	logic signed [osf_cfg_pkg::SUM_W-1:0] sum_shr;
	logic enter_sample;								// new window starts next edge

	//////////////////////////////
	// compare values
	//////////////////////////////

	// all ones shifted up by os then inverted leaves os low ones
	assign win_last = ~({osf_cfg_pkg::W_DELAY{1'b1}} << os_cur);
	assign dly_last = delay_cur - 1'b1;		// only read in DELAY where delay is nonzero

	//////////////////////////////
	// next state
	//////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (param.active)
					state_nxt = ST_SAMPLE;		// no settling before the first window
			end
			ST_SAMPLE: begin
				if (sample.valid && cnt == win_last)
					state_nxt = ST_SEND;		// last sample of the window
			end
			ST_SEND: begin
				// zero delay goes straight to the next window
				state_nxt = (delay_cur == '0) ? ST_SAMPLE : ST_DELAY;
			end
			ST_DELAY: begin
				if (sample.valid && cnt == dly_last)
					state_nxt = ST_SAMPLE;		// delay-th discard done
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	assign enter_sample = (state_nxt == ST_SAMPLE) && (state != ST_SAMPLE);

	//////////////////////////////
	// control registers
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in || !param.active) begin
			state <= ST_IDLE;		// deactivation acts as a local reset
			cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state_nxt != state)
				cnt <= '0;		// every state counts from zero
			else if (sample.valid && (state == ST_SAMPLE || state == ST_DELAY))
				cnt <= cnt + 1'b1;
		end
	end

	//////////////////////////////
	// accumulator
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (!param.active) begin
			sum <= '0;		// partial window dropped
		end else if (enter_sample) begin
			sum <= '0;
			os_cur <= param.os;		// window settings frozen here
			delay_cur <= param.delay;
		end else if (state == ST_SAMPLE && sample.valid) begin
			sum <= sum + sample.data;		// sign extended to SUM_W
		end
	end

	// divide by 2^os with floor then keep the low W_OUT bits
	assign sum_shr = sum >>> os_cur;
	assign out_data = sum_shr[osf_cfg_pkg::W_OUT-1:0];
	assign out_valid = (state == ST_SEND);		// one cycle per window

endmodule

/* src/osf_param_bank.sv */
`timescale 1ns/1ps

module osf_param_bank (
	input  logic clk_in,
	input  logic reset_in,
	input  osf_types_pkg::panel_t panel,					// live front panel words
	input  logic [osf_cfg_pkg::N_CHAN-1:0] update_en,		// per channel update mask
	input  logic update,									// load pulse
	output osf_types_pkg::param_vec_t params				// settings the filters run on
);

	//////////////////////////////
	// per channel latches
	//////////////////////////////

	genvar g;
	generate
		for (g = 0; g < osf_cfg_pkg::N_CHAN; g++) begin : g_chan
			logic load;		// this channel takes its panel word

			assign load = update && update_en[g];

			always_ff @(posedge clk_in) begin
				if (reset_in) begin
					// inactive with ratio 1 and no delay
					params[g].active <= 1'b0;
					params[g].os <= '0;
					params[g].delay <= '0;
				end else if (load) begin
					params[g].active <= panel[g].active;
					params[g].os <= panel[g].os;		// picked up at the next window
					params[g].delay <= panel[g].delay;
				end
			end
		end
	endgenerate

	// masked channels keep what they had
	// visible to the filters one cycle after the pulse

endmodule

/* src/osf_result_arbiter.sv */
`timescale 1ns/1ps

module osf_result_arbiter (
	input  logic clk_in,
	input  logic reset_in,
	input  osf_types_pkg::result_vec_t in_data,		// filter strobes and values
	output osf_types_pkg::osf_result_t result,		// tagged result toward the core
	output logic result_valid
);

	//////////////////////////////
	// declarations
	//////////////////////////////

	logic [osf_cfg_pkg::N_CHAN-1:0] pending;		// slot holds an unsent result
	logic [osf_cfg_pkg::N_CHAN-1:0] req;
	logic [osf_cfg_pkg::N_CHAN-1:0] gnt_oh;
	logic signed [osf_cfg_pkg::W_OUT-1:0] slot_data [osf_cfg_pkg::N_CHAN];
	logic [osf_cfg_pkg::CHAN_W-1:0] ptr;			// first channel to look at
	logic [osf_cfg_pkg::CHAN_W-1:0] gnt_idx;
	logic gnt_any;
	logic signed [osf_cfg_pkg::W_OUT-1:0] gnt_data;

	//////////////////////////////
	// round robin pick
	//////////////////////////////

	always_comb begin
		for (int ch = 0; ch < osf_cfg_pkg::N_CHAN; ch++)
			req[ch] = pending[ch] || in_data[ch].valid;		// fresh strobes bypass the slot
	end

	always_comb begin
		logic [osf_cfg_pkg::CHAN_W-1:0] idx;
		gnt_any = 1'b0;
		gnt_idx = ptr;
		gnt_oh = '0;
		// walk backwards so the nearest request wins
		for (int k = osf_cfg_pkg::N_CHAN - 1; k >= 0; k--) begin
			idx = ptr + k[osf_cfg_pkg::CHAN_W-1:0];		// wraps with the tag width
			if (req[idx]) begin
				gnt_any = 1'b1;
				gnt_idx = idx;
				gnt_oh = '0;
				gnt_oh[idx] = 1'b1;
			end
		end
	end

	// older pending value goes first
	assign gnt_data = pending[gnt_idx] ? slot_data[gnt_idx] : in_data[gnt_idx].data;

	//////////////////////////////
	// slots and pointer
	//////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			pending <= '0;
			ptr <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= gnt_any;
			if (gnt_any)
				ptr <= gnt_idx + 1'b1;		// skip past the winner
			for (int ch = 0; ch < osf_cfg_pkg::N_CHAN; ch++) begin
				if (gnt_oh[ch])
					pending[ch] <= pending[ch] && in_data[ch].valid;	// new strobe waits
				else if (in_data[ch].valid)
					pending[ch] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_in) begin
		for (int ch = 0; ch < osf_cfg_pkg::N_CHAN; ch++) begin
			if (in_data[ch].valid)
				slot_data[ch] <= in_data[ch].data;
		end
		result.chan <= gnt_idx;		// tag travels with the value
		result.data <= gnt_data;
	end

endmodule

/* src/osf_array_top.sv */
`timescale 1ns/1ps

module osf_array_top (
	input  logic clk_in,
	input  logic reset_in,
	input  osf_types_pkg::adc_bus_t adc,					// one sample stream per channel
	input  osf_types_pkg::panel_t panel,					// front panel words
	input  logic [osf_cfg_pkg::N_CHAN-1:0] update_en,
	input  logic update,
	output osf_types_pkg::osf_result_t result,			// shared result bus
	output logic result_valid
);

	//////////////////////////////
	// internal nets
	//////////////////////////////

	wire osf_types_pkg::param_vec_t params;		// bank to filters
	wire osf_types_pkg::result_vec_t filt;		// filters to arbiter

	//////////////////////////////
	// parameter bank
	//////////////////////////////

	osf_param_bank u_bank (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.panel     (panel),
		.update_en (update_en),
		.update    (update),
		.params    (params)
	);

	//////////////////////////////
	// filters
	//////////////////////////////

	genvar g;
	generate
		for (g = 0; g < osf_cfg_pkg::N_CHAN; g++) begin : g_filt
			oversample_filter u_filt (
				.clk_in    (clk_in),
				.reset_in  (reset_in),
				.sample    (adc[g]),
				.param     (params[g]),
				.out_data  (filt[g].data),
				.out_valid (filt[g].valid)
			);
		end
	endgenerate

	//////////////////////////////
	// result bus
	//////////////////////////////

	osf_result_arbiter u_arb (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.in_data      (filt),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

/* tb/osf_tb_clk.sv */
`timescale 1ns/1ps

module osf_tb_clk (
	output logic clk_in
);

	//////////////////////////////
	// 10 ns free running clock
	//////////////////////////////

	initial clk_in = 1'b0;

	always #5 clk_in = ~clk_in;		// half period

endmodule

/* tb/osf_sva.sv */
`timescale 1ns/1ps

module osf_sva (
	input logic clk_in,
	input logic reset_in,
	input osf_types_pkg::result_vec_t in_data,			// filter strobes into the arbiter
	input logic [osf_cfg_pkg::N_CHAN-1:0] pending,		// arbiter slot flags
	input osf_types_pkg::osf_result_t result,
	input logic result_valid
);

	logic [osf_cfg_pkg::N_CHAN-1:0] strobe;		// valid bits pulled out of the vector

	always_comb begin
		for (int ch = 0; ch < osf_cfg_pkg::N_CHAN; ch++)
			strobe[ch] = in_data[ch].valid;
	end

	// a refill before the drain would lose a result
	a_slot_free: assert property (@(posedge clk_in) disable iff (reset_in)
		(strobe & pending) == '0)
		else $error("pending slot written while it still held a result");

	// one grant per entry, so the same tag never repeats back to back
	a_single_grant: assert property (@(posedge clk_in) disable iff (reset_in)
		(result_valid && $past(result_valid)) |-> (result.chan != $past(result.chan)))
		else $error("result_valid held two cycles for one channel");

	a_reset_quiet: assert property (@(posedge clk_in)
		(reset_in && $past(reset_in)) |-> !result_valid)
		else $error("result_valid high during reset");

endmodule

bind osf_result_arbiter osf_sva i_sva (
	.clk_in       (clk_in),
	.reset_in     (reset_in),
	.in_data      (in_data),
	.pending      (pending),
	.result       (result),
	.result_valid (result_valid)
);

/* tb/osf_tb.sv */
`timescale 1ns/1ps

module osf_tb;

	localparam int N = osf_cfg_pkg::N_CHAN;
	localparam int RUN_LIMIT = 40000;		// cycles, far past the whole test list

	typedef struct packed {
		int os;
		int delay;
		int act;
	} word_t;		// one channel of panel or bank settings

	typedef struct packed {
		int run;		// channel active in the model
		int skip;		// discarding samples between windows
		int os;
		int delay;
		int cnt;
		longint sum;
	} win_t;

	logic clk_in;
	logic reset_in;
	osf_types_pkg::adc_bus_t adc;
	osf_types_pkg::panel_t panel;
	logic [N-1:0] update_en;
	logic update;
	osf_types_pkg::osf_result_t result;
	logic result_valid;

	string cur_test;
	int cycle_cnt;
	int rx_cnt;						// results seen on the bus
	int exp_chan [$];				// predicted results, oldest first
	int exp_data [$];
	word_t p_word [N];				// panel as driven
	word_t b_word [N];				// bank copy after gated updates
	win_t win [N];

	osf_tb_clk u_clk (.clk_in(clk_in));

	osf_array_top i_dut (
		.clk_in       (clk_in),
		.reset_in     (reset_in),
		.adc          (adc),
		.panel        (panel),
		.update_en    (update_en),
		.update       (update),
		.result       (result),
		.result_valid (result_valid)
	);

	//////////////////////////////
	// failure reporting
	//////////////////////////////

	task automatic fail_run(string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_eq(string what, int expected, int actual);
		if (expected != actual)
			fail_run($sformatf("Mismatch %s %s expected %0d actual %0d",
				cur_test, what, expected, actual));
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	// floor of sum / 2^os kept to W_OUT bits
	function automatic int window_avg(longint sum, int os);
		longint div;
		longint q;
		logic signed [osf_cfg_pkg::W_OUT-1:0] t;
		div = longint'(1) << os;
		q = sum / div;					// rounds toward zero
		if (sum < 0 && q * div != sum)
			q = q - 1;
		t = q[osf_cfg_pkg::W_OUT-1:0];
		return int'(t);
	endfunction

	function automatic void start_window(int ch);
		win[ch].os = b_word[ch].os;		// frozen for the whole window
		win[ch].delay = b_word[ch].delay;
		win[ch].cnt = 0;
		win[ch].sum = 0;
		win[ch].skip = 0;
	endfunction

	function automatic void model_sample(int ch, int data);
		if (win[ch].run == 0)
			return;						// idle channel drops it
		win[ch].cnt++;
		if (win[ch].skip != 0) begin
			if (win[ch].cnt == win[ch].delay)
				start_window(ch);		// delay-th discard
		end else begin
			win[ch].sum += data;
			if (win[ch].cnt == (1 << win[ch].os)) begin
				exp_chan.push_back(ch);
				exp_data.push_back(window_avg(win[ch].sum, win[ch].os));
				if (win[ch].delay == 0) begin
					start_window(ch);
				end else begin
					win[ch].skip = 1;
					win[ch].cnt = 0;
				end
			end
		end
	endfunction

	function automatic void model_update(logic [N-1:0] en);
		int was;
		for (int c = 0; c < N; c++) begin
			if (en[c]) begin
				was = b_word[c].act;
				b_word[c] = p_word[c];
				win[c].run = p_word[c].act;		// partial sum lost on deactivation
				if (p_word[c].act != 0 && was == 0)
					start_window(c);			// no settling before the first window
			end
		end
	endfunction

	//////////////////////////////
	// stimulus
	//////////////////////////////

	function automatic void set_panel(int ch, int os, int delay, int act);
		p_word[ch].os = os;
		p_word[ch].delay = delay;
		p_word[ch].act = act;
	endfunction

	task automatic pulse_update(logic [N-1:0] en);
		@(posedge clk_in);
		for (int c = 0; c < N; c++) begin
			panel[c].os <= p_word[c].os[osf_cfg_pkg::W_OS-1:0];
			panel[c].delay <= p_word[c].delay[osf_cfg_pkg::W_DELAY-1:0];
			panel[c].active <= p_word[c].act[0];
		end
		update_en <= en;
		update <= 1'b1;
		@(posedge clk_in);
		update <= 1'b0;
		update_en <= '0;
		model_update(en);
		repeat (2) @(posedge clk_in);		// filter out of idle before any sample
	endtask

	task automatic park_channel(int ch);
		logic [N-1:0] m;
		m = '0;
		m[ch] = 1'b1;
		set_panel(ch, 0, 0, 0);
		pulse_update(m);
	endtask

	task automatic send_samples(logic [N-1:0] mask, int count);
		logic [31:0] r;
		logic signed [osf_cfg_pkg::W_IN-1:0] d;
		repeat (count) begin
			@(posedge clk_in);
			for (int c = 0; c < N; c++) begin
				if (mask[c]) begin
					r = $urandom();
					d = r[osf_cfg_pkg::W_IN-1:0];		// full signed range
					adc[c].data <= d;
					adc[c].valid <= 1'b1;
					model_sample(c, int'(d));
				end
			end
			@(posedge clk_in);
			for (int c = 0; c < N; c++)
				adc[c].valid <= 1'b0;
			repeat (2) @(posedge clk_in);		// adc rate, one per 4 clocks
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_chan.size() != 0 && waited < 50) begin
			@(posedge clk_in);
			waited++;
		end
		if (exp_chan.size() != 0)
			fail_run($sformatf("%s: result for channel %0d never arrived",
				cur_test, exp_chan[0]));
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic test_average();
		int os_list [3] = '{0, 2, 7};
		int wins [3] = '{8, 3, 2};		// windows per ratio
		cur_test = "average";
		foreach (os_list[i]) begin
			set_panel(0, os_list[i], 0, 1);
			pulse_update(4'b0001);
			send_samples(4'b0001, wins[i] << os_list[i]);
			wait_drain();
			park_channel(0);
		end
	endtask

	task automatic test_delay();
		cur_test = "delay";
		set_panel(1, 1, 3, 1);
		pulse_update(4'b0010);
		send_samples(4'b0010, 25);		// five windows of 2, three skipped after each
		wait_drain();
		park_channel(1);
	endtask

	task automatic test_gated_update();
		cur_test = "gated_update";
		set_panel(2, 1, 0, 1);
		pulse_update(4'b0100);
		send_samples(4'b0100, 4);
		set_panel(2, 3, 0, 1);
		pulse_update(4'b1011);			// channel 2 masked, stays at os 1
		send_samples(4'b0100, 4);
		wait_drain();
		pulse_update(4'b0100);
		send_samples(4'b0100, 18);		// open os 1 window closes, then two of 8
		wait_drain();
		park_channel(2);
	endtask

	task automatic test_activation();
		cur_test = "activation";
		set_panel(3, 2, 0, 1);
		pulse_update(4'b1000);
		send_samples(4'b1000, 6);		// one window and half of the next
		wait_drain();
		park_channel(3);
		send_samples(4'b1000, 3);		// ignored while inactive
		set_panel(3, 2, 0, 1);
		pulse_update(4'b1000);
		send_samples(4'b1000, 8);
		wait_drain();
		park_channel(3);
	endtask

	task automatic test_shared_bus();
		int start;
		cur_test = "shared_bus";
		start = rx_cnt;
		for (int c = 0; c < N; c++)
			set_panel(c, 0, 0, 1);
		pulse_update('1);
		send_samples('1, 16);			// all strobes land on the same cycle
		repeat (N - 1) @(posedge clk_in);	// last tag at most N_CHAN cycles behind
		@(negedge clk_in);
		check_eq("results within latency", 16 * N, rx_cnt - start);
		for (int c = 0; c < N; c++)
			set_panel(c, 0, 0, 0);
		pulse_update('1);
	endtask

	//////////////////////////////
	// monitor and timeout
	//////////////////////////////

	always @(posedge clk_in) begin
		int idx;
		if (!reset_in && result_valid) begin
			idx = -1;
			for (int i = 0; i < exp_chan.size(); i++)
				if (idx < 0 && exp_chan[i] == int'(result.chan))
					idx = i;			// oldest entry for this tag
			if (idx < 0) begin
				fail_run($sformatf("%s: unexpected result on channel %0d",
					cur_test, result.chan));
			end else begin
				check_eq($sformatf("ch%0d result", result.chan), exp_data[idx],
					int'($signed(result.data)));
				exp_chan.delete(idx);
				exp_data.delete(idx);
				rx_cnt++;
			end
		end
	end

	always @(posedge clk_in) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt == RUN_LIMIT)
			fail_run("timeout: the run went past its cycle limit");
	end

	initial begin
		void'($urandom(32'h8bca_ad7f));
		cycle_cnt = 0;
		rx_cnt = 0;
		reset_in = 1'b1;
		adc = '0;
		panel = '0;
		update_en = '0;
		update = 1'b0;
		repeat (5) @(posedge clk_in);
		reset_in <= 1'b0;
		repeat (2) @(posedge clk_in);
		test_average();
		test_delay();
		test_gated_update();
		test_activation();
		test_shared_bus();
		repeat (20) @(posedge clk_in);		// catch any stray result
		if (exp_chan.size() == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			fail_run($sformatf("%0d results still outstanding", exp_chan.size()));
		end
	end

endmodule

/* filelist.f */
src/osf_cfg_pkg.sv
src/osf_types_pkg.sv
src/oversample_filter.sv
src/osf_param_bank.sv
src/osf_result_arbiter.sv
src/osf_array_top.sv
tb/osf_tb_clk.sv
tb/osf_sva.sv
tb/osf_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the osf testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module osf_tb --Mdir obj_dir -o osf_sim -f filelist.f; then
	echo "build failed"
	exit 1
fi

if [ ! -x obj_dir/osf_sim ]; then
	echo "simulation binary missing"
	exit 1
fi

./obj_dir/osf_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0
